// ==== design/bus_pkg.sv ====
/*
 * Shared bus types, host and device indices and the address map of the
 * compliance system. Imported by every design module.
 */
`default_nettype none

package bus_pkg;

  // One host transfer request
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } bus_req_t;

  // Response that travels with rvalid
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  // Bus hosts, highest priority first
  typedef enum logic [1:0] {
    TestUtilHost,
    CoreD,
    CoreI
  } host_e;

  typedef enum logic [0:0] {
    Ram,
    TestUtilDevice
  } device_e;

  localparam int NrHosts   = 3;
  localparam int NrDevices = 2;

  // 64 kB RAM window
  localparam logic [31:0] RamBase = 32'h0000_0000;
  localparam logic [31:0] RamMask = ~32'h0000_FFFF;
  localparam int          RamDepth = 16384;

  // 1 kB test utility window
  localparam logic [31:0] TestUtilBase = 32'h0002_0000;
  localparam logic [31:0] TestUtilMask = ~32'h0000_03FF;

  // Test utility register offsets
  localparam logic [31:0] TuHaltOffset     = 32'h0;
  localparam logic [31:0] TuSigBeginOffset = 32'h4;
  localparam logic [31:0] TuSigEndOffset   = 32'h8;

endpackage

`default_nettype wire

// ==== design/bus_arbiter.sv ====
/*
 * Fixed-priority arbiter for the shared bus. Grants the lowest-index host and
 * remembers it so the response one cycle later returns to that host only.
 */
`default_nettype none

module bus_arbiter
  import bus_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic [NrHosts-1:0] host_req_i,
  input  bus_req_t           host_pld_i [NrHosts],
  output logic [NrHosts-1:0] host_gnt_o,
  output logic [NrHosts-1:0] host_rvalid_o,
  output bus_rsp_t           host_rsp_o,

  output logic               bus_req_o,
  output bus_req_t           bus_pld_o,
  input  logic               bus_rvalid_i,
  input  bus_rsp_t           bus_rsp_i
);

  host_e sel_d;
  host_e sel_q;

  // Walk from lowest priority up so the highest requester wins
  always_comb begin
    sel_d = TestUtilHost;
    for (int i = NrHosts - 1; i >= 0; i--) begin
      if (host_req_i[i]) begin
        sel_d = host_e'(i);
      end
    end
  end

  assign bus_req_o = |host_req_i;
  assign bus_pld_o = host_pld_i[sel_d];

  always_comb begin
    host_gnt_o        = '0;
    host_gnt_o[sel_d] = bus_req_o;
  end

  // Owner of the transfer now in the decode stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= TestUtilHost;
    end else if (bus_req_o) begin
      sel_q <= sel_d;
    end
  end

  always_comb begin
    host_rvalid_o        = '0;
    host_rvalid_o[sel_q] = bus_rvalid_i;
  end

  // All hosts see the data, only the owner sees rvalid
  assign host_rsp_o = bus_rsp_i;

  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(host_gnt_o));

  // A response never arrives without a transfer granted the cycle before
  rsp_follows_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_rvalid_i |-> $past(bus_req_o));

endmodule

`default_nettype wire

// ==== design/bus_decoder.sv ====
/*
 * Address decode stage of the bus. Forwards a granted request to the matching
 * device and muxes the device response back, or answers unmapped addresses with err.
 */
`default_nettype none

module bus_decoder
  import bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 bus_req_i,
  input  bus_req_t             bus_pld_i,
  output logic                 bus_rvalid_o,
  output bus_rsp_t             bus_rsp_o,

  output logic [NrDevices-1:0] dev_req_o,
  output bus_req_t             dev_pld_o,
  input  logic [NrDevices-1:0] dev_rvalid_i,
  input  bus_rsp_t             dev_rsp_i [NrDevices]
);

  device_e sel_d;
  device_e sel_q;
  logic    match_d;
  logic    match_q;
  logic    req_q;

  // Devices see the offset inside their own window
  always_comb begin
    sel_d     = Ram;
    match_d   = 1'b0;
    dev_pld_o = bus_pld_i;
    if ((bus_pld_i.addr & RamMask) == RamBase) begin
      match_d        = 1'b1;
      dev_pld_o.addr = bus_pld_i.addr & ~RamMask;
    end else if ((bus_pld_i.addr & TestUtilMask) == TestUtilBase) begin
      sel_d          = TestUtilDevice;
      match_d        = 1'b1;
      dev_pld_o.addr = bus_pld_i.addr & ~TestUtilMask;
    end
    dev_req_o        = '0;
    dev_req_o[sel_d] = bus_req_i & match_d;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q   <= 1'b0;
      match_q <= 1'b0;
      sel_q   <= Ram;
    end else begin
      req_q   <= bus_req_i;
      match_q <= bus_req_i & match_d;
      sel_q   <= sel_d;
    end
  end

  // Unmapped transfers are answered here with err and no data
  always_comb begin
    if (match_q) begin
      bus_rvalid_o = dev_rvalid_i[sel_q];
      bus_rsp_o    = dev_rsp_i[sel_q];
    end else begin
      bus_rvalid_o = req_q;
      bus_rsp_o    = '{rdata: '0, err: 1'b1};
    end
  end

  dev_answers_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bus_req_i && match_d) |=> dev_rvalid_i[sel_q]);

endmodule

`default_nettype wire

// ==== design/ram_1p.sv ====
/*
 * Word-addressed single-port RAM with byte enables. Read data and rvalid are
 * registered, so every request is answered in the following cycle.
 */
`default_nettype none

module ram_1p
  import bus_pkg::*;
#(
  parameter int Depth = 1024
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     req_i,
  input  bus_req_t pld_i,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  logic [31:0]              mem [Depth];
  logic [$clog2(Depth)-1:0] word_addr;
  logic [31:0]              rdata_q;

  // Byte address in, word index out
  assign word_addr = pld_i.addr[$clog2(Depth)+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i && pld_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (pld_i.be[i]) begin
          mem[word_addr][8*i +: 8] <= pld_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= pld_i.we ? '0 : mem[word_addr];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: 1'b0};

  addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> !$isunknown(pld_i.addr));

endmodule

`default_nettype wire

// ==== design/riscv_testutil.sv ====
/*
 * Test utility device. Holds the signature range, and a write to halt starts a
 * host-side dump that reads the range and strobes each word out.
 */
`default_nettype none

module riscv_testutil
  import bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        dev_req_i,
  input  bus_req_t    dev_pld_i,
  output logic        dev_rvalid_o,
  output bus_rsp_t    dev_rsp_o,

  output logic        host_req_o,
  output bus_req_t    host_pld_o,
  input  logic        host_gnt_i,
  input  logic        host_rvalid_i,
  input  bus_rsp_t    host_rsp_i,

  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        halted_o
);

  typedef enum logic [2:0] {Idle, Req, Wait, Strobe, Done} state_e;

  state_e      state_q;
  logic [31:0] sig_begin_q;
  logic [31:0] sig_end_q;
  logic [31:0] addr_q;
  logic        halt_wr;
  bus_rsp_t    reg_rsp;

  assign halt_wr = dev_req_i && dev_pld_i.we && (dev_pld_i.addr == TuHaltOffset);

  // Register read mux where unknown offsets give err
  always_comb begin
    reg_rsp = '{rdata: '0, err: 1'b0};
    case (dev_pld_i.addr)
      TuHaltOffset:     reg_rsp.rdata = {31'b0, halted_o};
      TuSigBeginOffset: reg_rsp.rdata = sig_begin_q;
      TuSigEndOffset:   reg_rsp.rdata = sig_end_q;
      default:          reg_rsp.err   = 1'b1;
    endcase
    if (dev_pld_i.we) begin
      reg_rsp.rdata = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dev_rvalid_o <= 1'b0;
      sig_begin_q  <= '0;
      sig_end_q    <= '0;
    end else begin
      dev_rvalid_o <= dev_req_i;
      if (dev_req_i && dev_pld_i.we && dev_pld_i.addr == TuSigBeginOffset) begin
        sig_begin_q <= dev_pld_i.wdata;
      end
      if (dev_req_i && dev_pld_i.we && dev_pld_i.addr == TuSigEndOffset) begin
        sig_end_q <= dev_pld_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_req_i) begin
      dev_rsp_o <= reg_rsp;
    end
    if (host_rvalid_i) begin
      sig_data_o <= host_rsp_i.rdata;
    end
  end

  // Dump engine with one word in flight at a time
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      addr_q  <= '0;
    end else begin
      case (state_q)
        Idle: if (halt_wr) begin
          addr_q  <= sig_begin_q;
          state_q <= (sig_begin_q < sig_end_q) ? Req : Done;
        end
        Req:    if (host_gnt_i) state_q <= Wait;
        Wait: if (host_rvalid_i) begin
          addr_q  <= addr_q + 32'd4;
          state_q <= Strobe;
        end
        Strobe: state_q <= (addr_q < sig_end_q) ? Req : Done;
        default: state_q <= Done;
      endcase
    end
  end

  assign host_req_o  = (state_q == Req);
  assign host_pld_o  = '{addr: addr_q, we: 1'b0, be: 4'hF, wdata: '0};
  assign sig_valid_o = (state_q == Strobe);
  assign halted_o    = (state_q == Done);

  // The engine's own response arrives exactly in the cycle after its grant
  rsp_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_i == (state_q == Wait));

endmodule

`default_nettype wire

// ==== design/compliance_soc.sv ====
/*
 * Compliance test system without the core. The core's instruction and data
 * ports come in at the top and share the bus with the test utility host.
 */
`default_nettype none

module compliance_soc
  import bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic        instr_gnt_o,
  output logic        instr_rvalid_o,
  output bus_rsp_t    instr_rsp_o,

  input  logic        data_req_i,
  input  bus_req_t    data_pld_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output bus_rsp_t    data_rsp_o,

  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        halted_o
);

  logic [NrHosts-1:0]   host_req;
  logic [NrHosts-1:0]   host_gnt;
  logic [NrHosts-1:0]   host_rvalid;
  bus_req_t             host_pld [NrHosts];
  bus_rsp_t             host_rsp;

  logic                 bus_req;
  bus_req_t             bus_pld;
  logic                 bus_rvalid;
  bus_rsp_t             bus_rsp;

  logic [NrDevices-1:0] dev_req;
  logic [NrDevices-1:0] dev_rvalid;
  bus_req_t             dev_pld;
  bus_rsp_t             dev_rsp [NrDevices];

  // Instruction fetches are full-word reads
  assign host_req[CoreI] = instr_req_i;
  assign host_pld[CoreI] = '{addr: instr_addr_i, we: 1'b0, be: 4'hF, wdata: '0};
  assign host_req[CoreD] = data_req_i;
  assign host_pld[CoreD] = data_pld_i;

  assign instr_gnt_o    = host_gnt[CoreI];
  assign instr_rvalid_o = host_rvalid[CoreI];
  assign instr_rsp_o    = host_rsp;
  assign data_gnt_o     = host_gnt[CoreD];
  assign data_rvalid_o  = host_rvalid[CoreD];
  assign data_rsp_o     = host_rsp;

  bus_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req),
    .host_pld_i    (host_pld),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rsp_o    (host_rsp),
    .bus_req_o     (bus_req),
    .bus_pld_o     (bus_pld),
    .bus_rvalid_i  (bus_rvalid),
    .bus_rsp_i     (bus_rsp)
  );

  bus_decoder u_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus_req_i    (bus_req),
    .bus_pld_i    (bus_pld),
    .bus_rvalid_o (bus_rvalid),
    .bus_rsp_o    (bus_rsp),
    .dev_req_o    (dev_req),
    .dev_pld_o    (dev_pld),
    .dev_rvalid_i (dev_rvalid),
    .dev_rsp_i    (dev_rsp)
  );

  // Instruction and data storage
  ram_1p #(
    .Depth (RamDepth)
  ) u_ram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (dev_req[Ram]),
    .pld_i    (dev_pld),
    .rvalid_o (dev_rvalid[Ram]),
    .rsp_o    (dev_rsp[Ram])
  );

  riscv_testutil u_testutil (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .dev_req_i     (dev_req[TestUtilDevice]),
    .dev_pld_i     (dev_pld),
    .dev_rvalid_o  (dev_rvalid[TestUtilDevice]),
    .dev_rsp_o     (dev_rsp[TestUtilDevice]),
    .host_req_o    (host_req[TestUtilHost]),
    .host_pld_o    (host_pld[TestUtilHost]),
    .host_gnt_i    (host_gnt[TestUtilHost]),
    .host_rvalid_i (host_rvalid[TestUtilHost]),
    .host_rsp_i    (host_rsp),
    .sig_valid_o   (sig_valid_o),
    .sig_data_o    (sig_data_o),
    .halted_o      (halted_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_compliance_soc.sv ====
/*
 * Testbench for the compliance system. Acts as the core on both bus ports,
 * keeps a RAM model and checks every response and the signature dump.
 */
`default_nettype none

module tb_compliance_soc
  import bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RegionBase  = 32'h0000_1000;
  localparam int          RegionWords = 64;
  localparam int          MergeWrites = 32;
  localparam int          FetchReads  = 16;
  localparam int          SigWords    = 16;
  localparam int          RandomOps   = 200;
  // 23 directed accesses in the priority, unmapped and signature tests
  localparam int          NrOps       = 2 * RegionWords + MergeWrites + FetchReads + 23 +
                                        RandomOps;
  localparam int          CycleLimit  = NrOps * 4 + 4 * SigWords + 200;

  typedef struct packed {
    host_e    host;
    bus_rsp_t rsp;
    int       cycle;
  } pend_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        instr_req_i;
  logic [31:0] instr_addr_i;
  logic        instr_gnt_o;
  logic        instr_rvalid_o;
  bus_rsp_t    instr_rsp_o;
  logic        data_req_i;
  bus_req_t    data_pld_i;
  logic        data_gnt_o;
  logic        data_rvalid_o;
  bus_rsp_t    data_rsp_o;
  logic        sig_valid_o;
  logic [31:0] sig_data_o;
  logic        halted_o;
  logic        tu_host_req;

  // Reference state
  logic [31:0] model [RamDepth];
  logic [31:0] tu_begin     = '0;
  logic [31:0] tu_end       = '0;
  logic        tu_halted    = 1'b0;
  logic        dump_started = 1'b0;
  logic        halted_seen  = 1'b0;
  logic [31:0] sig_ptr      = '0;
  pend_t       pend_q [$];
  int          sig_count    = 0;
  int          last_strobe  = 0;
  int          cycles       = 0;
  int          checks       = 0;
  int          errors       = 0;
  int          err_mark     = 0;
  int          seed         = 81;

  compliance_soc dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rsp_o    (instr_rsp_o),
    .data_req_i     (data_req_i),
    .data_pld_i     (data_pld_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rsp_o     (data_rsp_o),
    .sig_valid_o    (sig_valid_o),
    .sig_data_o     (sig_data_o),
    .halted_o       (halted_o)
  );

  // Dump engine request for the priority check
  assign tu_host_req = dut.host_req[TestUtilHost];

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return (addr * 32'h0001_0003) ^ 32'hC3A5_0F1E;
  endfunction

  // Expected response from the RAM model and the address map
  function automatic bus_rsp_t expected_rsp(logic [31:0] addr, logic we);
    bus_rsp_t rsp;
    rsp = '{rdata: '0, err: 1'b0};
    if ((addr & RamMask) == RamBase) begin
      if (!we) begin
        rsp.rdata = model[addr[15:2]];
      end
    end else if ((addr & TestUtilMask) == TestUtilBase) begin
      case (addr & ~TestUtilMask)
        TuHaltOffset:     rsp.rdata = {31'b0, tu_halted};
        TuSigBeginOffset: rsp.rdata = tu_begin;
        TuSigEndOffset:   rsp.rdata = tu_end;
        default:          rsp.err   = 1'b1;
      endcase
      if (we) begin
        rsp.rdata = '0;
      end
    end else begin
      rsp.err = 1'b1;
    end
    return rsp;
  endfunction

  task automatic model_write(logic [31:0] addr, logic [3:0] be, logic [31:0] wdata);
    if ((addr & RamMask) == RamBase) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          model[addr[15:2]][8*i +: 8] = wdata[8*i +: 8];
        end
      end
    end else if ((addr & TestUtilMask) == TestUtilBase) begin
      case (addr & ~TestUtilMask)
        TuSigBeginOffset: tu_begin = wdata;
        TuSigEndOffset:   tu_end = wdata;
        TuHaltOffset: begin
          dump_started = 1'b1;
          sig_ptr      = tu_begin;
        end
        default: ;
      endcase
    end
  endtask

  task automatic check_rsp(string name, bus_rsp_t got, bus_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got rdata %h err %b, expected rdata %h err %b",
               $time, name, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic record_grant(host_e host, bus_req_t pld);
    pend_t pend;
    pend.host  = host;
    pend.rsp   = expected_rsp(pld.addr, pld.we);
    pend.cycle = cycles;
    pend_q.push_back(pend);
    if (pld.we) begin
      model_write(pld.addr, pld.be, pld.wdata);
    end
  endtask

  task automatic take_rsp(host_e host, string port, bus_rsp_t got);
    pend_t pend;
    if (pend_q.size() == 0) begin
      errors++;
      $display("Error at %0t: response on %s with no request pending", $time, port);
    end else begin
      pend = pend_q.pop_front();
      if (pend.host != host || cycles != pend.cycle + 1) begin
        errors++;
        $display("Error at %0t: response on %s does not belong to the grant before it",
                 $time, port);
      end
      check_rsp(port, got, pend.rsp);
    end
  endtask

  // Outputs are checked at the falling edge where they are stable
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (data_rvalid_o) begin
        take_rsp(CoreD, "data_rsp_o", data_rsp_o);
      end
      if (instr_rvalid_o) begin
        take_rsp(CoreI, "instr_rsp_o", instr_rsp_o);
      end
      if (data_gnt_o) begin
        record_grant(CoreD, data_pld_i);
      end
      if (instr_gnt_o) begin
        record_grant(CoreI, '{addr: instr_addr_i, we: 1'b0, be: 4'hF, wdata: '0});
      end
      // Fixed priority between the three hosts
      if (data_req_i || tu_host_req) begin
        check_bit("instr_gnt_o", instr_gnt_o, 1'b0);
      end
      if (tu_host_req) begin
        check_bit("data_gnt_o", data_gnt_o, 1'b0);
      end
      if (sig_valid_o) begin
        if (!dump_started || sig_ptr >= tu_end) begin
          errors++;
          $display("Error at %0t: signature strobe with no word left to dump", $time);
        end else begin
          check_word("sig_data_o", sig_data_o, model[sig_ptr[15:2]]);
        end
        sig_ptr     = sig_ptr + 32'd4;
        sig_count   = sig_count + 1;
        last_strobe = cycles;
      end
      if (halted_o && !halted_seen) begin
        halted_seen = 1'b1;
        check_bit("halted_o", halted_o,
                  dump_started && (sig_ptr == tu_end) && (cycles == last_strobe + 1));
      end
    end
  end

  // Stand-in core requests start 1 ns after a rising edge
  task automatic data_access(logic we, logic [31:0] addr, logic [3:0] be,
                             logic [31:0] wdata);
    data_req_i = 1'b1;
    data_pld_i = '{addr: addr, we: we, be: be, wdata: wdata};
    do begin
      @(negedge clk_i);
    end while (!data_gnt_o);
    @(posedge clk_i);
    #1;
    data_req_i = 1'b0;
  endtask

  task automatic instr_access(logic [31:0] addr);
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    do begin
      @(negedge clk_i);
    end while (!instr_gnt_o);
    @(posedge clk_i);
    #1;
    instr_req_i = 1'b0;
  endtask

  task automatic data_read(logic [31:0] addr);
    data_access(1'b0, addr, 4'hF, '0);
  endtask

  task automatic end_test(string name);
    do begin
      @(negedge clk_i);
      #1;
    end while (pend_q.size() != 0);
    @(posedge clk_i);
    #1;
    $display("Test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] addr;
    rst_n_i      = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_pld_i   = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    for (int i = 0; i < RegionWords; i++) begin
      addr = RegionBase + 32'(i * 4);
      data_access(1'b1, addr, 4'hF, fill_word(addr));
    end
    for (int i = 0; i < MergeWrites; i++) begin
      rnd = $random(seed);
      data_access(1'b1, RegionBase + {24'b0, rnd[13:8], 2'b00}, rnd[3:0], $random(seed));
    end
    for (int i = 0; i < RegionWords; i++) begin
      data_read(RegionBase + 32'(i * 4));
    end
    end_test("byte_enable_writes");

    for (int i = 0; i < FetchReads; i++) begin
      instr_access(RegionBase + 32'(i * 8));
    end
    end_test("instruction_fetch");

    fork
      data_read(RegionBase + 32'h0C);
      instr_access(RegionBase + 32'h14);
      begin
        @(negedge clk_i);
        check_bit("data_gnt_o", data_gnt_o, 1'b1);
        check_bit("instr_gnt_o", instr_gnt_o, 1'b0);
        @(negedge clk_i);
        check_bit("data_rvalid_o", data_rvalid_o, 1'b1);
        check_bit("instr_gnt_o", instr_gnt_o, 1'b1);
      end
    join
    end_test("port_priority");

    data_read(32'h0004_0000);
    data_access(1'b1, 32'h0003_0010, 4'hF, 32'h1234_5678);
    instr_access(32'h0010_0000);
    data_read(TestUtilBase + 32'h00C);
    data_access(1'b1, TestUtilBase + 32'h010, 4'hF, 32'hDEAD_BEEF);
    data_read(TestUtilBase + 32'h3FC);
    end_test("unmapped_access");

    // Signature window in the middle of the initialized region
    data_read(TestUtilBase + TuHaltOffset);
    data_access(1'b1, TestUtilBase + TuSigBeginOffset, 4'hF, RegionBase + 32'h40);
    data_access(1'b1, TestUtilBase + TuSigEndOffset, 4'hF,
                RegionBase + 32'h40 + 32'(SigWords * 4));
    data_read(TestUtilBase + TuSigBeginOffset);
    data_read(TestUtilBase + TuSigEndOffset);
    data_access(1'b1, TestUtilBase + TuHaltOffset, 4'hF, 32'h1);
    for (int i = 0; i < 8; i++) begin
      data_read(RegionBase + 32'(i * 4));
    end
    while (!halted_o) begin
      @(negedge clk_i);
    end
    tu_halted = 1'b1;
    end_test("signature_wait");
    check_word("signature word count", sig_count, SigWords);
    data_read(TestUtilBase + TuHaltOffset);
    end_test("signature_dump");

    for (int n = 0; n < RandomOps; n++) begin
      rnd  = $random(seed);
      addr = RegionBase + {24'b0, rnd[13:8], 2'b00};
      case (rnd[17:16])
        2'd0: data_access(1'b1, addr, rnd[3:0], $random(seed));
        2'd1: data_read(addr);
        2'd2: instr_access(addr);
        default: begin
          fork
            data_read(addr);
            instr_access(RegionBase + {24'b0, rnd[29:24], 2'b00});
          join
        end
      endcase
    end
    end_test("random_mix");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
design/bus_pkg.sv
design/bus_arbiter.sv
design/bus_decoder.sv
design/ram_1p.sv
design/riscv_testutil.sv
design/compliance_soc.sv
verif/tb_compliance_soc.sv

// ==== Makefile ====
# Verilator build and run of the compliance system testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_compliance_soc
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  build  compile the testbench and RTL with Verilator"
	@echo "  test   build, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Result: FAIL, run did not end"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
